//--- build.f
rtl/sd_share_pkg.sv
rtl/sdreq_filter.sv
rtl/sd_grant_arbiter.sv
rtl/spi_line_select.sv
rtl/sd_share_top.sv
sim/tb_sd_share.sv

//--- rtl/sd_grant_arbiter.sv
// fixed priority sd card grant arbiter with hold until release, plus its assertions
`default_nettype none

module sd_grant_arbiter
   import sd_share_pkg::*;
#(
   parameter int N_CTRL = SD_N_CTRL_DEF  // requesters
) (
   input  wire               sdclock,    // sd card clock
   input  wire               rst_i,      // sync reset, active high
   input  wire  [N_CTRL-1:0] req_filt_i, // filtered requests
   output logic [N_CTRL-1:0] grant_o,    // one-hot or zero, also the sdack lines
   output sd_owner_t         owner_o,    // index of the owner
   output logic              owned_o     // card is held
);

   arb_state_e        state_q;           // idle or owned
   logic [N_CTRL-1:0] grant_q;           // registered grant
   sd_owner_t         owner_q;           // who holds the card
   logic              pick_valid;        // some request is up
   sd_owner_t         pick_idx;          // lowest active index
   logic [N_CTRL-1:0] pick_vec;          // same, one-hot

   //********************
   // priority pick
   //********************
   // walk down from the top so the lowest index wins
   always_comb begin
      pick_valid = 1'b0;
      pick_idx   = '0;
      pick_vec   = '0;
      for (int k = N_CTRL - 1; k >= 0; k--) begin
         if (req_filt_i[k]) begin
            pick_valid  = 1'b1;
            pick_idx    = sd_owner_t'(k);
            pick_vec    = '0;            // drop the weaker candidate
            pick_vec[k] = 1'b1;
         end
      end
   end

   //********************
   // grant fsm
   //********************
   always_ff @(posedge sdclock) begin
      if (rst_i) begin
         state_q <= ARB_IDLE;
         grant_q <= '0;
         owner_q <= '0;
      end else begin
         unique case (state_q)
            ARB_IDLE: begin
               if (pick_valid) begin
                  grant_q <= pick_vec;   // ack rises next edge
                  owner_q <= pick_idx;
                  state_q <= ARB_OWNED;
               end
            end
            ARB_OWNED: begin
               // no preemption, only the owner's release frees the card
               if (!req_filt_i[owner_q]) begin
                  grant_q <= '0;
                  state_q <= ARB_IDLE;   // at least one idle cycle before next grant
               end
            end
            default: begin
               grant_q <= '0;
               state_q <= ARB_IDLE;
            end
         endcase
      end
   end

   assign grant_o = grant_q;
   assign owner_o = owner_q;
   assign owned_o = (state_q == ARB_OWNED);

   //********************
   // checks
   //********************
   // only one controller on the card at a time
   a_grant_onehot0 : assert property (@(posedge sdclock) disable iff (rst_i)
      $onehot0(grant_q))
      else $error("sd grant has more than one bit set: %b", grant_q);

   // a handover always goes through an all-zero grant
   a_grant_no_swap : assert property (@(posedge sdclock) disable iff (rst_i)
      (grant_q != '0) && ($past(grant_q) != '0) |-> (grant_q == $past(grant_q)))
      else $error("sd grant moved between owners without release");

   // owner keeps the card while its filtered request stays up
   a_grant_held : assert property (@(posedge sdclock) disable iff (rst_i)
      (state_q == ARB_OWNED) && req_filt_i[owner_q] |=> $stable(grant_q))
      else $error("sd grant dropped under an active request");

endmodule

`default_nettype wire

//--- rtl/sd_share_pkg.sv
// controller names, arbiter states, default sizes and owner index type for the sd card share
`default_nettype none

package sd_share_pkg;

   //********************
   // controllers
   //********************
   // vector positions in priority order, highest first
   typedef enum logic [2:0] {
      CTRL_RK = 3'd0,                    // rk11 cartridge disk
      CTRL_DW = 3'd1,                    // dw winchester
      CTRL_DM = 3'd2,                    // rk611
      CTRL_DB = 3'd3,                    // rh70 massbus disk
      CTRL_DX = 3'd4,                    // rx01 floppy
      CTRL_MY = 3'd5                     // my floppy, lowest priority
   } sd_ctrl_e;

   //********************
   // arbiter
   //********************
   typedef enum logic [0:0] {
      ARB_IDLE  = 1'b0,                  // card free, looking for a request
      ARB_OWNED = 1'b1                   // card held by one controller
   } arb_state_e;

   //********************
   // sizes
   //********************
   localparam int SD_N_CTRL_DEF = 6;     // controllers on the card
   localparam int SD_SYNC_DEF   = 2;     // request filter depth
   localparam int SD_OWNER_W    = 3;     // owner index width

   typedef logic [SD_OWNER_W-1:0] sd_owner_t; // index of the card owner

endpackage

`default_nettype wire

//--- rtl/sd_share_top.sv
// sd card share top, request filter, grant arbiter and spi line selector chained
`default_nettype none

module sd_share_top
   import sd_share_pkg::*;
#(
   parameter int N_CTRL       = SD_N_CTRL_DEF, // controllers sharing the card
   parameter int SYNC_STAGES  = SD_SYNC_DEF,   // request filter depth
   parameter int DEFAULT_CTRL = int'(CTRL_RK)  // idle owner of the pins
) (
   input  wire               sdclock,      // sd card clock
   input  wire               rst_i,        // sync reset, active high
   input  wire  [N_CTRL-1:0] sdreq_i,      // card requests, one per controller
   output logic [N_CTRL-1:0] sdack_o,      // card grants
   input  wire  [N_CTRL-1:0] ctrl_cs_i,    // controller chip selects
   input  wire  [N_CTRL-1:0] ctrl_mosi_i,  // controller data out
   input  wire  [N_CTRL-1:0] ctrl_sclk_i,  // controller serial clocks
   output logic              sdcard_cs_o,  // to the card
   output logic              sdcard_mosi_o,
   output logic              sdcard_sclk_o,
   input  wire               sdcard_miso_i, // from the card
   output logic              sdcard_miso_o  // shared by every controller
);

   wire [N_CTRL-1:0] req_filt;           // filtered requests
   wire sd_owner_t   owner;              // current owner index
   wire              owned;              // card held

   // miso goes to everyone, only the owner listens
   assign sdcard_miso_o = sdcard_miso_i;

   //********************
   // stage 1
   //********************
   sdreq_filter #(
      .N_CTRL      (N_CTRL),
      .SYNC_STAGES (SYNC_STAGES)
   ) u_filter (
      .sdclock     (sdclock),
      .rst_i       (rst_i),
      .sdreq_i     (sdreq_i),
      .req_filt_o  (req_filt)
   );

   //********************
   // stage 2
   //********************
   sd_grant_arbiter #(
      .N_CTRL      (N_CTRL)
   ) u_arbiter (
      .sdclock     (sdclock),
      .rst_i       (rst_i),
      .req_filt_i  (req_filt),
      .grant_o     (sdack_o),            // grant is the ack
      .owner_o     (owner),
      .owned_o     (owned)
   );

   //********************
   // stage 3
   //********************
   spi_line_select #(
      .N_CTRL       (N_CTRL),
      .DEFAULT_CTRL (DEFAULT_CTRL)
   ) u_select (
      .owner_i       (owner),
      .owned_i       (owned),
      .ctrl_cs_i     (ctrl_cs_i),
      .ctrl_mosi_i   (ctrl_mosi_i),
      .ctrl_sclk_i   (ctrl_sclk_i),
      .sdcard_cs_o   (sdcard_cs_o),
      .sdcard_mosi_o (sdcard_mosi_o),
      .sdcard_sclk_o (sdcard_sclk_o)
   );

endmodule

`default_nettype wire

//--- rtl/sdreq_filter.sv
// request filter, shift register per controller request line in the sdclock domain
`default_nettype none

module sdreq_filter
   import sd_share_pkg::*;
#(
   parameter int N_CTRL      = SD_N_CTRL_DEF, // request lines
   parameter int SYNC_STAGES = SD_SYNC_DEF    // flops per line, 1 or more
) (
   input  wire               sdclock,     // sd card clock
   input  wire               rst_i,       // sync reset, active high
   input  wire  [N_CTRL-1:0] sdreq_i,     // raw requests from the controllers
   output logic [N_CTRL-1:0] req_filt_o   // filtered requests to the arbiter
);

   //********************
   // shift chain
   //********************
   // stage 0 samples the raw lines, last stage feeds the arbiter
   logic [N_CTRL-1:0] sync_q [SYNC_STAGES];

   always_ff @(posedge sdclock) begin
      if (rst_i) begin
         for (int i = 0; i < SYNC_STAGES; i++) begin
            sync_q[i] <= '0;             // no request seen after reset
         end
      end else begin
         sync_q[0] <= sdreq_i;           // first capture, may be late by one edge
         for (int i = 1; i < SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];    // shift toward the arbiter
         end
      end
   end

   // a change on sdreq_i seen at edge E shows here at E+SYNC_STAGES-1
   assign req_filt_o = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

//--- rtl/spi_line_select.sv
// sd card spi line selector, owner's lines when owned, default controller's lines when idle
`default_nettype none

module spi_line_select
   import sd_share_pkg::*;
#(
   parameter int N_CTRL       = SD_N_CTRL_DEF, // controllers on the card
   parameter int DEFAULT_CTRL = 0              // drives the pins when idle
) (
   input  wire sd_owner_t   owner_i,     // owner index from the arbiter
   input  wire              owned_i,     // owner_i is valid
   input  wire [N_CTRL-1:0] ctrl_cs_i,   // chip select per controller
   input  wire [N_CTRL-1:0] ctrl_mosi_i, // data out per controller
   input  wire [N_CTRL-1:0] ctrl_sclk_i, // serial clock per controller
   output logic             sdcard_cs_o,   // card chip select
   output logic             sdcard_mosi_o, // card data in
   output logic             sdcard_sclk_o  // card clock
);

   sd_owner_t sel_idx;                   // controller on the pins right now

   //********************
   // source select
   //********************
   // idle pins stay with the controller that drives the card as spi master
   assign sel_idx = owned_i ? owner_i : sd_owner_t'(DEFAULT_CTRL);

   //********************
   // line mux
   //********************
   // pure combinational, pins follow the grant in the same cycle
   always_comb begin
      sdcard_cs_o   = ctrl_cs_i[sel_idx];
      sdcard_mosi_o = ctrl_mosi_i[sel_idx];
      sdcard_sclk_o = ctrl_sclk_i[sel_idx];
   end

   // arbiter must never hand over an index beyond the wired controllers
   always_comb begin
      if (owned_i) begin
         a_owner_range : assert (int'(owner_i) < N_CTRL)
            else $error("sd owner index %0d out of range", owner_i);
      end
   end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# builds the sd card share testbench with verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f build.f --top-module tb_sd_share -o tb_sd_share
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/tb_sd_share)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qxF '*** TEST PASSED ***'; then
   exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- sim/sd_share_stimulus.txt
// columns: test id, request vector driven, acknowledge vector expected (hex, bit 0 = rk)
// one line per cycle, ack follows a request change 3 lines later, ff ends the file
// 1 reset state
01 00 00
01 00 00
// 2 lone db request, ack up and down 2 cycles after sampling
02 08 00
02 08 00
02 08 00
02 08 08
02 08 08
02 08 08
02 00 08
02 00 08
02 00 08
02 00 00
// 3 my, dm and dw together, served dw, dm, my
03 26 00
03 26 00
03 26 00
03 26 02
03 26 02
03 24 02
03 24 02
03 24 02
03 24 00
03 24 04
03 24 04
03 20 04
03 20 04
03 20 04
03 20 00
03 20 20
03 20 20
03 00 20
03 00 20
03 00 20
03 00 00
// 4 rk waits while dx holds the card
04 10 00
04 10 00
04 10 00
04 10 10
04 11 10
04 11 10
04 11 10
04 11 10
04 01 10
04 01 10
04 01 10
04 01 00
04 01 01
04 01 01
04 00 01
04 00 01
04 00 01
04 00 00
// 5 mixed four-phase traffic
05 0c 00
05 0c 00
05 0c 00
05 0c 04
05 2c 04
05 28 04
05 28 04
05 28 04
05 28 00
05 28 08
05 2a 08
05 22 08
05 22 08
05 22 08
05 22 00
05 22 02
05 20 02
05 20 02
05 20 02
05 20 00
05 20 20
05 30 20
05 10 20
05 10 20
05 10 20
05 10 00
05 10 10
05 00 10
05 00 10
05 00 10
05 00 00
ff 00 00

//--- sim/tb_sd_share.sv
// testbench for the sd card share top, file driven requests with acknowledge and pin checks
`default_nettype none

module tb_sd_share
   import sd_share_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int N         = SD_N_CTRL_DEF; // controllers on the card
   localparam int MAX_LINES = 128;           // stimulus line limit
   localparam int N_TESTS   = 5;
   localparam int IDLE_WAIT = 20;            // cycles allowed for final ack release

   logic         sdclock;
   logic         rst_i;
   logic [N-1:0] sdreq_i;
   logic [N-1:0] ctrl_cs_i;
   logic [N-1:0] ctrl_mosi_i;
   logic [N-1:0] ctrl_sclk_i;
   logic         sdcard_miso_i;
   wire  [N-1:0] sdack_o;
   wire          sdcard_cs_o;
   wire          sdcard_mosi_o;
   wire          sdcard_sclk_o;
   wire          sdcard_miso_o;

   logic [7:0] stim_mem [0:3*MAX_LINES-1]; // test id, request, expected ack per line
   integer     seed;                       // $random seed
   int         errors;
   int         checks;
   int         tests_run;
   int         tests_ok;
   int         test_err;                   // errors in the running test
   int         test_cycles;
   logic [7:0] cur_test;

   sd_share_top DUT (
      .sdclock       (sdclock),
      .rst_i         (rst_i),
      .sdreq_i       (sdreq_i),
      .sdack_o       (sdack_o),
      .ctrl_cs_i     (ctrl_cs_i),
      .ctrl_mosi_i   (ctrl_mosi_i),
      .ctrl_sclk_i   (ctrl_sclk_i),
      .sdcard_cs_o   (sdcard_cs_o),
      .sdcard_mosi_o (sdcard_mosi_o),
      .sdcard_sclk_o (sdcard_sclk_o),
      .sdcard_miso_i (sdcard_miso_i),
      .sdcard_miso_o (sdcard_miso_o)
   );

   //********************
   // clock
   //********************
   initial begin
      sdclock = 1'b0;
      forever #10 sdclock = ~sdclock;   // 20 ns period
   end

   //********************
   // helpers
   //********************
   // pins follow the acked controller or controller 0 when nobody holds the card
   function automatic logic [2:0] pin_source(input logic [N-1:0] ack);
      logic [2:0] idx;
      idx = 3'd0;
      for (int k = 0; k < N; k++) begin
         if (ack[k]) begin
            idx = 3'(k);
         end
      end
      return idx;
   endfunction

   function automatic string test_name(input logic [7:0] id);
      case (id)
         8'd1:    return "reset state";
         8'd2:    return "single request latency";
         8'd3:    return "fixed priority";
         8'd4:    return "no preemption";
         8'd5:    return "mutual exclusion under traffic";
         default: return "unknown";
      endcase
   endfunction

   // new request vector plus fresh random spi lines
   task automatic drive_cycle(input logic [N-1:0] req);
      logic [31:0] rnd;
      rnd           = $random(seed);
      sdreq_i       = req;
      ctrl_cs_i     = rnd[5:0];
      ctrl_mosi_i   = rnd[11:6];
      ctrl_sclk_i   = rnd[17:12];
      sdcard_miso_i = rnd[18];
   endtask

   task automatic check_cycle(input logic [N-1:0] exp_ack);
      logic [2:0] src;
      sd_ctrl_e   src_name;
      arb_state_e exp_state;
      src       = pin_source(exp_ack);
      src_name  = sd_ctrl_e'(src);
      exp_state = (exp_ack == '0) ? ARB_IDLE : ARB_OWNED;
      checks++;
      if (sdack_o !== exp_ack) begin
         $display("FAILED at %0d ns: sdack_o %02h, expected %02h with arbiter %s",
                  $time, sdack_o, exp_ack, exp_state.name());
         test_err++;
      end
      if ($countones(sdack_o) > 1) begin
         $display("FAILED at %0d ns: sdack_o %02h has more than one owner", $time, sdack_o);
         test_err++;
      end
      if (sdcard_cs_o !== ctrl_cs_i[src]) begin
         $display("FAILED at %0d ns: sdcard_cs_o %b, expected %b from %s",
                  $time, sdcard_cs_o, ctrl_cs_i[src], src_name.name());
         test_err++;
      end
      if (sdcard_mosi_o !== ctrl_mosi_i[src]) begin
         $display("FAILED at %0d ns: sdcard_mosi_o %b, expected %b from %s",
                  $time, sdcard_mosi_o, ctrl_mosi_i[src], src_name.name());
         test_err++;
      end
      if (sdcard_sclk_o !== ctrl_sclk_i[src]) begin
         $display("FAILED at %0d ns: sdcard_sclk_o %b, expected %b from %s",
                  $time, sdcard_sclk_o, ctrl_sclk_i[src], src_name.name());
         test_err++;
      end
      if (sdcard_miso_o !== sdcard_miso_i) begin
         $display("FAILED at %0d ns: sdcard_miso_o %b, card drives %b",
                  $time, sdcard_miso_o, sdcard_miso_i);
         test_err++;
      end
   endtask

   task automatic report_test();
      tests_run++;
      errors += test_err;
      if (test_err == 0) begin
         tests_ok++;
      end
      $display("test %0d %s: %s, %0d cycles, %0d errors", cur_test, test_name(cur_test),
               (test_err == 0) ? "ok" : "failed", test_cycles, test_err);
   endtask

   // every ack must drop once the traffic ends
   task automatic wait_ack_clear(input int limit);
      int n;
      n = 0;
      while (sdack_o !== '0 && n < limit) begin
         @(posedge sdclock);
         #2;
         sdreq_i = '0;                  // all requests withdrawn
         #16;                           // sample just before the next edge
         n++;
      end
      if (sdack_o !== '0) begin
         $display("timeout: sdack_o still %02h after %0d cycles at end of stimulus",
                  sdack_o, limit);
         errors++;
      end
   endtask

   //********************
   // main sequence
   //********************
   initial begin
      int         line;
      logic       done;
      logic [8:0] base;                 // word address of the line
      logic [7:0] id;
      logic [7:0] req;
      logic [7:0] ack;
      rst_i         = 1'b1;
      sdreq_i       = '0;
      ctrl_cs_i     = '0;
      ctrl_mosi_i   = '0;
      ctrl_sclk_i   = '0;
      sdcard_miso_i = 1'b0;
      seed          = 8;
      errors        = 0;
      checks        = 0;
      tests_run     = 0;
      tests_ok      = 0;
      test_err      = 0;
      test_cycles   = 0;
      cur_test      = 8'h00;
      $readmemh("sim/sd_share_stimulus.txt", stim_mem);

      for (int c = 0; c < 10; c++) begin
         @(posedge sdclock);            // reset held 10 cycles
      end
      #2;
      rst_i = 1'b0;

      line = 0;
      done = 1'b0;
      while (!done && line < MAX_LINES) begin
         base = 9'(3 * line);
         id   = stim_mem[base];
         req  = stim_mem[base + 9'd1];
         ack  = stim_mem[base + 9'd2];
         if (id != cur_test) begin
            if (cur_test != 8'h00) begin
               report_test();
            end
            cur_test    = id;
            test_err    = 0;
            test_cycles = 0;
         end
         if (id == 8'hff) begin
            done = 1'b1;                // end marker
         end else if (id == 8'h00 || id > 8'(N_TESTS)) begin
            $display("stimulus file has no valid test number on line %0d", line);
            errors++;
            done = 1'b1;
         end else begin
            @(posedge sdclock);
            #2;                         // drive after the edge
            drive_cycle(req[N-1:0]);
            #16;                        // sample just before the next edge
            check_cycle(ack[N-1:0]);
            test_cycles++;
            line++;
         end
      end
      if (!done) begin
         $display("timeout: stimulus file end marker not found within %0d lines", MAX_LINES);
         errors++;
         report_test();
      end

      wait_ack_clear(IDLE_WAIT);
      if (tests_run != N_TESTS) begin
         $display("stimulus file ran %0d tests instead of %0d", tests_run, N_TESTS);
         errors++;
      end

      $display("summary: %0d tests, %0d ok, %0d failed, %0d checks, %0d errors",
               tests_run, tests_ok, tests_run - tests_ok, checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire
